// File: verilog/arb_bus_pkg.sv
package arb_bus_pkg;

	// Memory port address width
	localparam int ADDR_W = 32;

	// Read and write data width
	localparam int DATA_W = 32;

	// Byte address as seen by both masters and the memory
	typedef logic [ADDR_W-1:0] addr_t;

	// One data word
	typedef logic [DATA_W-1:0] data_t;

endpackage

// File: verilog/arb_ctrl_pkg.sv
package arb_ctrl_pkg;

	// Owner of an outstanding request
	typedef logic [0:0] master_id_t;

	localparam master_id_t MASTER_INSTR = 1'b0;
	localparam master_id_t MASTER_DATA  = 1'b1;

	// Priority mode of the issue FSM
	typedef enum logic [0:0] {
		ARB_PRIO_M0,
		ARB_FORCE_M1
	} arb_state_t;

endpackage

// File: verilog/arbiter_issue_fsm.sv
`timescale 1ns/1ps

module arbiter_issue_fsm (
	input  logic                 iCLOCK,
	input  logic                 inRESET,
	// Instruction fetch master
	input  logic                 m0_req,
	input  arb_bus_pkg::addr_t   m0_addr,
	output logic                 m0_gnt,
	// Data access master
	input  logic                 m1_req,
	input  logic                 m1_we,
	input  arb_bus_pkg::addr_t   m1_addr,
	input  arb_bus_pkg::data_t   m1_wdata,
	output logic                 m1_gnt,
	// Memory request side
	output logic                 mem_req,
	output logic                 mem_we,
	output arb_bus_pkg::addr_t   mem_addr,
	output arb_bus_pkg::data_t   mem_wdata,
	input  logic                 mem_busy,
	// Matching queue push side
	output logic                 push,
	output arb_ctrl_pkg::master_id_t push_owner,
	input  logic                 queue_full,
	// From the starvation timer
	input  logic                 starve_expired
);

	import arb_ctrl_pkg::*;

	arb_state_t state_q;
	arb_state_t state_d;

	logic issue_ok;
	logic sel_m0;
	logic sel_m1;

	// A request can only leave when memory and queue both have room
	assign issue_ok = !mem_busy && !queue_full;

	// Pick the winner for this cycle
	always_comb begin
		sel_m0 = 1'b0;
		sel_m1 = 1'b0;
		if (issue_ok) begin
			if (state_q == ARB_FORCE_M1) begin
				// Data master goes first after starving
				if (m1_req) begin
					sel_m1 = 1'b1;
				end else if (m0_req) begin
					sel_m0 = 1'b1;
				end
			end else begin
				if (m0_req) begin
					sel_m0 = 1'b1;
				end else if (m1_req) begin
					sel_m1 = 1'b1;
				end
			end
		end
	end

	assign m0_gnt = sel_m0;
	assign m1_gnt = sel_m1;

	// Winner's operands go straight to memory
	assign mem_req   = sel_m0 || sel_m1;
	assign mem_we    = sel_m1 && m1_we;
	assign mem_addr  = sel_m1 ? m1_addr : m0_addr;
	assign mem_wdata = m1_wdata;

	// Owner is recorded in the same cycle as the issue
	assign push       = mem_req;
	assign push_owner = sel_m1 ? MASTER_DATA : MASTER_INSTR;

	// Priority mode
	always_comb begin
		state_d = state_q;
		case (state_q)
			ARB_PRIO_M0: begin
				if (starve_expired && !sel_m1) begin
					state_d = ARB_FORCE_M1;
				end
			end
			ARB_FORCE_M1: begin
				// Back to normal once master 1 is served or gives up
				if (sel_m1 || !m1_req) begin
					state_d = ARB_PRIO_M0;
				end
			end
			default: begin
				state_d = ARB_PRIO_M0;
			end
		endcase
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state_q <= ARB_PRIO_M0;
		end else begin
			state_q <= state_d;
		end
	end

endmodule

// File: verilog/arbiter_starve_timer.sv
`timescale 1ns/1ps

module arbiter_starve_timer #(
	parameter int STARVE_LIMIT = 4
) (
	input  logic iCLOCK,
	input  logic inRESET,
	input  logic m1_req,
	input  logic m1_gnt,
	output logic starve_expired
);

	// Wide enough to hold STARVE_LIMIT itself
	localparam int CNT_W = $clog2(STARVE_LIMIT + 1);

	logic [CNT_W-1:0] wait_cnt;

	assign starve_expired = (wait_cnt == CNT_W'(STARVE_LIMIT));

	// Counts cycles master 1 waits without a grant
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			wait_cnt <= '0;
		end else if (!m1_req || m1_gnt) begin
			wait_cnt <= '0;
		end else if (!starve_expired) begin
			// Saturate at the limit
			wait_cnt <= wait_cnt + CNT_W'(1);
		end
	end

endmodule

// File: verilog/arbiter_matching_queue.sv
`timescale 1ns/1ps

module arbiter_matching_queue #(
	parameter int QUEUE_DEPTH   = 8,
	parameter int QUEUE_DEPTH_N = 3
) (
	input  logic                      iCLOCK,
	input  logic                      inRESET,
	// Pipeline flush
	input  logic                      flush,
	// Push side
	input  logic                      wr_req,
	input  arb_ctrl_pkg::master_id_t  wr_flag,
	output logic                      wr_full,
	// Pop side
	input  logic                      rd_req,
	output logic                      rd_valid,
	output arb_ctrl_pkg::master_id_t  rd_flag,
	output logic                      rd_empty
);

	import arb_ctrl_pkg::*;

	// One extra bit tells full from empty
	logic [QUEUE_DEPTH_N:0]   wr_cnt;
	logic [QUEUE_DEPTH_N:0]   rd_cnt;
	logic [QUEUE_DEPTH_N:0]   fill;
	logic [QUEUE_DEPTH_N-1:0] wr_idx;
	logic [QUEUE_DEPTH_N-1:0] rd_idx;

	logic       [QUEUE_DEPTH-1:0] entry_valid;
	master_id_t                   owner_mem [QUEUE_DEPTH];

	logic do_push;
	logic do_pop;

	assign fill     = wr_cnt - rd_cnt;
	assign wr_full  = fill[QUEUE_DEPTH_N];
	assign rd_empty = (wr_cnt == rd_cnt);

	assign wr_idx = wr_cnt[QUEUE_DEPTH_N-1:0];
	assign rd_idx = rd_cnt[QUEUE_DEPTH_N-1:0];

	assign do_push = wr_req && !wr_full;
	assign do_pop  = rd_req && !rd_empty;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			wr_cnt      <= '0;
			rd_cnt      <= '0;
			entry_valid <= '0;
		end else begin
			// Flush kills every outstanding entry but keeps the counters
			if (flush) begin
				entry_valid <= '0;
			end
			if (do_push) begin
				wr_cnt              <= wr_cnt + 1'b1;
				entry_valid[wr_idx] <= 1'b1;
			end
			if (do_pop) begin
				rd_cnt              <= rd_cnt + 1'b1;
				entry_valid[rd_idx] <= 1'b0;
			end
		end
	end

	// Owner flags
	always_ff @(posedge iCLOCK) begin
		if (do_push) begin
			owner_mem[wr_idx] <= wr_flag;
		end
	end

	// Head entry counts as flushed already in the flush cycle
	assign rd_valid = entry_valid[rd_idx] && !flush;
	assign rd_flag  = owner_mem[rd_idx];

endmodule

// File: verilog/arbiter_response_router.sv
`timescale 1ns/1ps

module arbiter_response_router (
	// Memory response
	input  logic                      mem_rvalid,
	input  arb_bus_pkg::data_t        mem_rdata,
	// Head of the matching queue
	output logic                      rd_req,
	input  logic                      rd_valid,
	input  arb_ctrl_pkg::master_id_t  rd_flag,
	// Instruction master response
	output logic                      m0_rvalid,
	output arb_bus_pkg::data_t        m0_rdata,
	// Data master response
	output logic                      m1_rvalid,
	output arb_bus_pkg::data_t        m1_rdata
);

	import arb_ctrl_pkg::*;

	logic deliver;

	// Every response retires one queue entry
	assign rd_req = mem_rvalid;

	// Flushed entries swallow their response
	assign deliver = mem_rvalid && rd_valid;

	assign m0_rvalid = deliver && (rd_flag == MASTER_INSTR);
	assign m1_rvalid = deliver && (rd_flag == MASTER_DATA);

	// Data is shared, the valid pulse picks the owner
	assign m0_rdata = mem_rdata;
	assign m1_rdata = mem_rdata;

endmodule

// File: verilog/mem_arbiter_top.sv
`timescale 1ns/1ps

module mem_arbiter_top #(
	parameter int QUEUE_DEPTH   = 8,
	parameter int QUEUE_DEPTH_N = 3,
	parameter int STARVE_LIMIT  = 4
) (
	input  logic               iCLOCK,
	input  logic               inRESET,
	input  logic               flush,
	// Instruction fetch master
	input  logic               m0_req,
	input  arb_bus_pkg::addr_t m0_addr,
	output logic               m0_gnt,
	output logic               m0_rvalid,
	output arb_bus_pkg::data_t m0_rdata,
	// Data access master
	input  logic               m1_req,
	input  logic               m1_we,
	input  arb_bus_pkg::addr_t m1_addr,
	input  arb_bus_pkg::data_t m1_wdata,
	output logic               m1_gnt,
	output logic               m1_rvalid,
	output arb_bus_pkg::data_t m1_rdata,
	// Shared memory port
	output logic               mem_req,
	output logic               mem_we,
	output arb_bus_pkg::addr_t mem_addr,
	output arb_bus_pkg::data_t mem_wdata,
	input  logic               mem_busy,
	input  logic               mem_rvalid,
	input  arb_bus_pkg::data_t mem_rdata
);

	import arb_ctrl_pkg::*;

	// Issue side to queue
	logic       push;
	master_id_t push_owner;
	logic       queue_full;

	// Queue to response side
	logic       pop;
	logic       head_valid;
	master_id_t head_owner;

	logic starve_expired;

	arbiter_issue_fsm u_issue (
		.iCLOCK         (iCLOCK),
		.inRESET        (inRESET),
		.m0_req         (m0_req),
		.m0_addr        (m0_addr),
		.m0_gnt         (m0_gnt),
		.m1_req         (m1_req),
		.m1_we          (m1_we),
		.m1_addr        (m1_addr),
		.m1_wdata       (m1_wdata),
		.m1_gnt         (m1_gnt),
		.mem_req        (mem_req),
		.mem_we         (mem_we),
		.mem_addr       (mem_addr),
		.mem_wdata      (mem_wdata),
		.mem_busy       (mem_busy),
		.push           (push),
		.push_owner     (push_owner),
		.queue_full     (queue_full),
		.starve_expired (starve_expired)
	);

	arbiter_starve_timer #(
		.STARVE_LIMIT (STARVE_LIMIT)
	) u_starve (
		.iCLOCK         (iCLOCK),
		.inRESET        (inRESET),
		.m1_req         (m1_req),
		.m1_gnt         (m1_gnt),
		.starve_expired (starve_expired)
	);

	// Empty flag is not needed here, the router pops only on responses
	arbiter_matching_queue #(
		.QUEUE_DEPTH   (QUEUE_DEPTH),
		.QUEUE_DEPTH_N (QUEUE_DEPTH_N)
	) u_queue (
		.iCLOCK   (iCLOCK),
		.inRESET  (inRESET),
		.flush    (flush),
		.wr_req   (push),
		.wr_flag  (push_owner),
		.wr_full  (queue_full),
		.rd_req   (pop),
		.rd_valid (head_valid),
		.rd_flag  (head_owner),
		.rd_empty ()
	);

	arbiter_response_router u_router (
		.mem_rvalid (mem_rvalid),
		.mem_rdata  (mem_rdata),
		.rd_req     (pop),
		.rd_valid   (head_valid),
		.rd_flag    (head_owner),
		.m0_rvalid  (m0_rvalid),
		.m0_rdata   (m0_rdata),
		.m1_rvalid  (m1_rvalid),
		.m1_rdata   (m1_rdata)
	);

endmodule

// File: verif/mem_arbiter_assert.sv
`timescale 1ns/1ps

module mem_arbiter_assert (
	input logic iCLOCK,
	input logic inRESET,
	input logic m0_gnt,
	input logic m1_gnt,
	input logic mem_req,
	input logic mem_busy,
	input logic m0_rvalid,
	input logic m1_rvalid
);

	// Number of failed assertions so far
	int fail_cnt = 0;

	// At most one master wins a cycle
	grant_onehot: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		!(m0_gnt && m1_gnt))
	else begin
		$error("Both grants high in the same cycle");
		fail_cnt++;
	end

	// Busy memory takes no new request
	no_req_when_busy: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		mem_busy |-> !mem_req)
	else begin
		$error("Memory request issued while memory is busy");
		fail_cnt++;
	end

	grant_with_req: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		(m0_gnt || m1_gnt) |-> mem_req)
	else begin
		$error("Grant without a memory request");
		fail_cnt++;
	end

	// One response goes to one owner only
	rvalid_exclusive: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		!(m0_rvalid && m1_rvalid))
	else begin
		$error("Both response valids high in the same cycle");
		fail_cnt++;
	end

endmodule

bind mem_arbiter_top mem_arbiter_assert u_assert (
	.iCLOCK    (iCLOCK),
	.inRESET   (inRESET),
	.m0_gnt    (m0_gnt),
	.m1_gnt    (m1_gnt),
	.mem_req   (mem_req),
	.mem_busy  (mem_busy),
	.m0_rvalid (m0_rvalid),
	.m1_rvalid (m1_rvalid)
);

// File: verif/mem_arbiter_tb.sv
`timescale 1ns/1ps

module mem_arbiter_tb;

	import arb_bus_pkg::*;

	localparam int QUEUE_DEPTH   = 8;
	localparam int QUEUE_DEPTH_N = 3;
	localparam int STARVE_LIMIT  = 4;
	localparam int CLK_PERIOD    = 100;
	localparam int TIMEOUT       = 200;

	logic  iCLOCK;
	logic  inRESET;
	logic  flush;
	logic  m0_req;
	addr_t m0_addr;
	logic  m0_gnt;
	logic  m0_rvalid;
	data_t m0_rdata;
	logic  m1_req;
	logic  m1_we;
	addr_t m1_addr;
	data_t m1_wdata;
	logic  m1_gnt;
	logic  m1_rvalid;
	data_t m1_rdata;
	logic  mem_req;
	logic  mem_we;
	addr_t mem_addr;
	data_t mem_wdata;
	logic  mem_busy;
	logic  mem_rvalid;
	data_t mem_rdata;

	// Memory model, responses in order after a patterned delay
	data_t resp_data [$];
	int    resp_due [$];
	int    cycle_cnt;
	int    delay_idx;
	logic  resp_hold;
	int    delay_pat [6] = '{1, 3, 2, 2, 1, 3};

	// Expected read data per master, flushed entries marked
	data_t exp_data [2][$];
	bit    exp_drop [2][$];
	int    rx_count;
	int    base_rx;
	string test_name;

	mem_arbiter_top #(
		.QUEUE_DEPTH   (QUEUE_DEPTH),
		.QUEUE_DEPTH_N (QUEUE_DEPTH_N),
		.STARVE_LIMIT  (STARVE_LIMIT)
	) dut0 (.*);

	initial begin
		iCLOCK = 1'b0;
		forever #(CLK_PERIOD / 2) iCLOCK = ~iCLOCK;
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic check_equal(input string what, input data_t expected, input data_t actual);
		assert (actual === expected) else begin
			abort_run($sformatf("Error %s: expected %h, actual %h", what, expected, actual));
		end
	endtask

	// Live entries plus memory responses still to come
	function automatic int pending();
		int n;
		n = resp_data.size();
		for (int m = 0; m < 2; m++) begin
			for (int i = 0; i < exp_drop[m].size(); i++) begin
				if (!exp_drop[m][i]) begin
					n++;
				end
			end
		end
		return n;
	endfunction

	task automatic check_response(input int m, input data_t actual);
		while (exp_drop[m].size() > 0 && exp_drop[m][0]) begin
			void'(exp_data[m].pop_front());
			void'(exp_drop[m].pop_front());
		end
		assert (exp_data[m].size() > 0) else begin
			abort_run($sformatf("Master %0d got a response with no request outstanding", m));
		end
		check_equal($sformatf("%s m%0d data", test_name, m), exp_data[m].pop_front(), actual);
		void'(exp_drop[m].pop_front());
		rx_count++;
	endtask

	task automatic wait_grant(input bit which);
		bit got;
		got = 1'b0;
		for (int n = 0; n < TIMEOUT && !got; n++) begin
			@(posedge iCLOCK);
			got = which ? m1_gnt : m0_gnt;
		end
		assert (got) else begin
			abort_run($sformatf("Timed out waiting for the grant of master %0d", which));
		end
	endtask

	task automatic issue_m0(input addr_t a);
		@(negedge iCLOCK);
		m0_req  = 1'b1;
		m0_addr = a;
		wait_grant(1'b0);
	endtask

	task automatic issue_m1(input logic we, input addr_t a, input data_t wd);
		@(negedge iCLOCK);
		m1_req   = 1'b1;
		m1_we    = we;
		m1_addr  = a;
		m1_wdata = wd;
		wait_grant(1'b1);
	endtask

	// Master 1 read against a busy master 0, counts ungranted cycles
	task automatic check_starvation(input addr_t a);
		int waited;
		bit got;
		waited = 0;
		got    = 1'b0;
		@(negedge iCLOCK);
		m1_req  = 1'b1;
		m1_we   = 1'b0;
		m1_addr = a;
		for (int n = 0; n < TIMEOUT && !got; n++) begin
			@(posedge iCLOCK);
			if (m1_gnt) begin
				got = 1'b1;
			end else begin
				waited++;
			end
		end
		assert (got && waited <= STARVE_LIMIT + 1) else begin
			abort_run($sformatf("Error %s: expected wait <= %0d, actual %0d",
				test_name, STARVE_LIMIT + 1, waited));
		end
		@(negedge iCLOCK);
		m1_req = 1'b0;
	endtask

	task automatic drain();
		bit idle;
		idle = 1'b0;
		for (int n = 0; n < TIMEOUT && !idle; n++) begin
			@(posedge iCLOCK);
			#(CLK_PERIOD / 4);
			idle = (pending() == 0);
		end
		assert (idle) else begin
			abort_run("Timed out waiting for outstanding responses");
		end
	endtask

	always @(posedge iCLOCK) begin
		cycle_cnt++;
		if (inRESET && mem_req) begin
			resp_data.push_back(mem_we ? data_t'(0) : ~mem_addr);
			resp_due.push_back(cycle_cnt + delay_pat[delay_idx]);
			delay_idx = (delay_idx + 1) % 6;
		end
	end

	always @(negedge iCLOCK) begin
		mem_rvalid = 1'b0;
		mem_rdata  = '0;
		if (!resp_hold && resp_due.size() > 0) begin
			if (resp_due[0] <= cycle_cnt) begin
				mem_rvalid = 1'b1;
				mem_rdata  = resp_data.pop_front();
				void'(resp_due.pop_front());
			end
		end
	end

	// Flush marks first, then responses, then new issues
	always @(posedge iCLOCK) begin
		if (inRESET) begin
			if (flush) begin
				for (int m = 0; m < 2; m++) begin
					for (int i = 0; i < exp_drop[m].size(); i++) begin
						exp_drop[m][i] = 1'b1;
					end
				end
			end
			if (m0_rvalid) begin
				check_response(0, m0_rdata);
			end
			if (m1_rvalid) begin
				check_response(1, m1_rdata);
			end
			if (m0_gnt) begin
				exp_data[0].push_back(~m0_addr);
				exp_drop[0].push_back(1'b0);
			end
			if (m1_gnt) begin
				// Write data reaches memory with the grant
				if (m1_we) begin
					check_equal($sformatf("%s m1 wdata", test_name), m1_wdata, mem_wdata);
				end
				exp_data[1].push_back(m1_we ? data_t'(0) : ~m1_addr);
				exp_drop[1].push_back(1'b0);
			end
		end
	end

	always @(negedge iCLOCK) begin
		if (dut0.u_assert.fail_cnt != 0) begin
			abort_run("A bound assertion on the arbiter ports failed");
		end
	end

	initial begin
		inRESET    = 1'b0;
		flush      = 1'b0;
		m0_req     = 1'b0;
		m0_addr    = '0;
		m1_req     = 1'b0;
		m1_we      = 1'b0;
		m1_addr    = '0;
		m1_wdata   = '0;
		mem_busy   = 1'b0;
		mem_rvalid = 1'b0;
		mem_rdata  = '0;
		resp_hold  = 1'b0;
		cycle_cnt  = 0;
		delay_idx  = 0;
		rx_count   = 0;
		test_name  = "reset";
		repeat (8) @(negedge iCLOCK);
		inRESET = 1'b1;
		repeat (5) begin
			@(posedge iCLOCK);
			check_equal(test_name, '0, {m0_gnt, m1_gnt, mem_req, m0_rvalid, m1_rvalid});
		end

		// Interleaved traffic, one write among the data reads
		test_name = "ordering";
		fork
			begin
				for (int i = 0; i < 6; i++) begin
					issue_m0(32'h0000_1000 + i * 4);
				end
				@(negedge iCLOCK);
				m0_req = 1'b0;
			end
			begin
				for (int i = 0; i < 6; i++) begin
					issue_m1(i == 3, 32'h0000_2000 + i * 4, 32'h5a5a_0000 + i);
				end
				@(negedge iCLOCK);
				m1_req = 1'b0;
			end
		join
		drain();

		test_name = "busy";
		@(negedge iCLOCK);
		mem_busy = 1'b1;
		m0_req   = 1'b1;
		m0_addr  = 32'h0000_4000;
		repeat (4) begin
			@(posedge iCLOCK);
			check_equal(test_name, '0, {m0_gnt, mem_req});
		end
		@(negedge iCLOCK);
		mem_busy = 1'b0;
		wait_grant(1'b0);
		@(negedge iCLOCK);
		m0_req = 1'b0;
		drain();

		// Held responses keep the matching queue full
		test_name = "full";
		resp_hold <= 1'b1;
		for (int i = 0; i < QUEUE_DEPTH; i++) begin
			issue_m0(32'h0000_5000 + i * 4);
		end
		@(negedge iCLOCK);
		m0_addr = 32'h0000_5100;
		repeat (4) begin
			@(posedge iCLOCK);
			check_equal(test_name, '0, {m0_gnt, mem_req});
		end
		@(negedge iCLOCK);
		resp_hold <= 1'b0;
		wait_grant(1'b0);
		@(negedge iCLOCK);
		m0_req = 1'b0;
		drain();

		test_name = "starvation";
		fork
			begin
				for (int i = 0; i < 10; i++) begin
					issue_m0(32'h0000_6000 + i * 4);
				end
				@(negedge iCLOCK);
				m0_req = 1'b0;
			end
			begin
				repeat (2) @(negedge iCLOCK);
				check_starvation(32'h0000_7000);
			end
		join
		drain();

		// Three requests die in the flush, two later ones must answer
		test_name = "flush";
		base_rx   = rx_count;
		resp_hold <= 1'b1;
		issue_m0(32'h0000_8000);
		issue_m0(32'h0000_8004);
		@(negedge iCLOCK);
		m0_req = 1'b0;
		issue_m1(1'b0, 32'h0000_8100, '0);
		@(negedge iCLOCK);
		m1_req = 1'b0;
		flush  = 1'b1;
		@(negedge iCLOCK);
		flush = 1'b0;
		resp_hold <= 1'b0;
		issue_m1(1'b0, 32'h0000_8200, '0);
		@(negedge iCLOCK);
		m1_req = 1'b0;
		issue_m0(32'h0000_8300);
		@(negedge iCLOCK);
		m0_req = 1'b0;
		drain();
		check_equal("flush response count", 2, rx_count - base_rx);

		if (dut0.u_assert.fail_cnt != 0) begin
			abort_run("A bound assertion on the arbiter ports failed");
		end else begin
			$display("Regression passed");
			$finish;
		end
	end

endmodule

// File: project.f
verilog/arb_bus_pkg.sv
verilog/arb_ctrl_pkg.sv
verilog/arbiter_issue_fsm.sv
verilog/arbiter_starve_timer.sv
verilog/arbiter_matching_queue.sv
verilog/arbiter_response_router.sv
verilog/mem_arbiter_top.sv
verif/mem_arbiter_assert.sv
verif/mem_arbiter_tb.sv
